// ==== project.f ====
+incdir+source
source/axi_types_pkg.sv
source/mem_types_pkg.sv
source/axi_mem_array.sv
source/axi_write_ctrl.sv
source/axi_read_ctrl.sv
source/axi_ram_top.sv
dv/axi_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the AXI RAM testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module axi_ram_tb -f project.f -o axi_ram_sim

./obj_dir/axi_ram_sim > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== dv/axi_ram_tb.sv ====
// self-checking testbench for the AXI RAM, fixed test addresses need MEM_DEPTH_LOG2 of at least 10
`timescale 1ns/100ps
`include "axi_mem_defs.svh"

module axi_ram_tb;
    import axi_types_pkg::*;

    localparam int        DEPTH    = 1 << `MEM_DEPTH_LOG2;
    localparam int        TIMEOUT  = 200;
    localparam axi_addr_t TOP_ADDR = axi_addr_t'(DEPTH * 8);

    logic        clk;
    logic        rst;
    axi_aw_t     i_aw;
    logic        i_aw_valid;
    logic        o_aw_ready;
    axi_w_t      i_w;
    logic        i_w_valid;
    logic        o_w_ready;
    axi_b_t      o_b;
    logic        o_b_valid;
    logic        i_b_ready;
    axi_ar_t     i_ar;
    logic        i_ar_valid;
    logic        o_ar_ready;
    axi_r_t      o_r;
    logic        o_r_valid;
    logic        i_r_ready;

    logic [7:0]  shadow [DEPTH*8];
    logic [15:0] lfsr;
    axi_ar_t     rd_q [$];
    axi_b_t      b_q [$];
    int          r_beat;
    axi_r_t      r_held;
    logic        r_waiting;
    int          errors;
    int          checks;
    int          err_mark;
    logic        timeout_hit;

    axi_ram_top UUT (
        .clk        (clk),
        .rst        (rst),
        .i_aw       (i_aw),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_w        (i_w),
        .i_w_valid  (i_w_valid),
        .o_w_ready  (o_w_ready),
        .o_b        (o_b),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .i_ar       (i_ar),
        .i_ar_valid (i_ar_valid),
        .o_ar_ready (o_ar_ready),
        .o_r        (o_r),
        .o_r_valid  (o_r_valid),
        .i_r_ready  (i_r_ready)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            if (lfsr[0]) begin
                lfsr = (lfsr >> 1) ^ 16'hB400;
            end else begin
                lfsr = lfsr >> 1;
            end
        end
        return v;
    endfunction

    function automatic logic pick_ready(input logic stall);
        logic [63:0] v;
        if (!stall) begin
            return 1'b1;
        end
        v = rand_bits(1);
        return v[0];
    endfunction

    function automatic logic in_range(input axi_addr_t addr, input axi_len_t len);
        longint last_word;
        last_word = longint'(addr[`AXI_ADDR_W-1:3]) + longint'(len);
        return last_word < longint'(DEPTH);
    endfunction

    function automatic void merge_shadow(input axi_addr_t addr, input int beat, input axi_w_t w);
        int word;
        word = int'(addr[`AXI_ADDR_W-1:3]) + beat;
        for (int b = 0; b < 8; b++) begin
            if (w.strb[b]) begin
                shadow[word*8 + b] = w.data[b*8 +: 8];
            end
        end
    endfunction

    // expected R beat from the shadow bytes and the range rule
    function automatic axi_r_t expect_beat(input axi_ar_t req, input int beat);
        axi_r_t r;
        int     word;
        r.id   = req.id;
        r.last = (beat == int'(req.len));
        if (in_range(req.addr, req.len)) begin
            word = int'(req.addr[`AXI_ADDR_W-1:3]) + beat;
            for (int b = 0; b < 8; b++) begin
                r.data[b*8 +: 8] = shadow[word*8 + b];
            end
            r.resp = RESP_OKAY;
        end else begin
            r.data = '0;
            r.resp = RESP_SLVERR;
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic raise_timeout(input string what);
        errors++;
        timeout_hit = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_r_beat();
        axi_r_t exp_r;
        if (rd_q.size() == 0) begin
            report_error("R transfer with no read open");
        end else begin
            exp_r = expect_beat(rd_q[0], r_beat);
            check_data("o_r.data", o_r.data, exp_r.data);
            check_resp("o_r.resp", o_r.resp, exp_r.resp);
            check_id("o_r.id", o_r.id, exp_r.id);
            checks++;
            if (o_r.last !== exp_r.last) begin
                errors++;
                $display("[FAIL] o_r.last got %h expected %h on beat %0d",
                         o_r.last, exp_r.last, r_beat);
            end
            r_beat++;
            if (r_beat > int'(rd_q[0].len)) begin
                void'(rd_q.pop_front());
                r_beat = 0;
            end
        end
    endtask

    task automatic check_b();
        axi_b_t exp_b;
        if (b_q.size() == 0) begin
            report_error("B response with no write open");
        end else begin
            exp_b = b_q.pop_front();
            check_id("o_b.id", o_b.id, exp_b.id);
            check_resp("o_b.resp", o_b.resp, exp_b.resp);
        end
    endtask

    // compares in the stable window before each rising edge
    always begin
        @(negedge clk);
        #1;
        if (rst) begin
            r_waiting = 1'b0;
        end else begin
            if (r_waiting && (!o_r_valid || o_r !== r_held)) begin
                report_error("R channel changed while valid waited for ready");
            end
            r_waiting = o_r_valid && !i_r_ready;
            r_held    = o_r;
            if (o_r_valid && i_r_ready) begin
                check_r_beat();
            end
            if (o_b_valid && i_b_ready) begin
                check_b();
            end
        end
    end

    task automatic apply_reset();
        rst        = 1'b1;
        i_aw       = '0;
        i_aw_valid = 1'b0;
        i_w        = '0;
        i_w_valid  = 1'b0;
        i_b_ready  = 1'b0;
        i_ar       = '0;
        i_ar_valid = 1'b0;
        i_r_ready  = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        if (o_aw_ready || o_w_ready || o_ar_ready || o_b_valid || o_r_valid) begin
            report_error("a ready or valid is high right after reset");
        end
    endtask

    task automatic write_burst(input axi_addr_t addr, input axi_id_t id, input axi_len_t len,
                               input logic rnd_strb, input logic stall);
        axi_b_t      exp_b;
        logic        ok;
        logic [63:0] rnd;
        int          t;
        int          beat;
        ok         = in_range(addr, len);
        exp_b.id   = id;
        exp_b.resp = ok ? RESP_OKAY : RESP_SLVERR;
        b_q.push_back(exp_b);
        i_aw.addr  = addr;
        i_aw.id    = id;
        i_aw.len   = len;
        i_aw_valid = 1'b1;
        t = 0;
        while (!o_aw_ready && !timeout_hit) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                raise_timeout("AW ready");
            end
        end
        @(negedge clk);
        i_aw_valid = 1'b0;
        beat = 0;
        while (beat <= int'(len) && !timeout_hit) begin
            i_w.data = rand_bits(64);
            rnd = rnd_strb ? rand_bits(8) : 64'hFF;
            i_w.strb  = rnd[7:0];
            i_w.last  = (beat == int'(len));
            i_w_valid = 1'b1;
            t = 0;
            while (!o_w_ready && !timeout_hit) begin
                @(negedge clk);
                t++;
                if (t > TIMEOUT) begin
                    raise_timeout("W ready");
                end
            end
            if (ok) begin
                merge_shadow(addr, beat, i_w);
            end
            beat++;
            @(negedge clk);
        end
        i_w_valid = 1'b0;
        i_b_ready = pick_ready(stall);
        t = 0;
        while (!(o_b_valid && i_b_ready) && !timeout_hit) begin
            @(negedge clk);
            i_b_ready = pick_ready(stall);
            t++;
            if (t > TIMEOUT) begin
                raise_timeout("B transfer");
            end
        end
        @(negedge clk);
        i_b_ready = 1'b0;
    endtask

    task automatic read_burst(input axi_addr_t addr, input axi_id_t id, input axi_len_t len,
                              input logic stall);
        axi_ar_t req;
        int      t;
        int      beats;
        req.addr = addr;
        req.id   = id;
        req.len  = len;
        rd_q.push_back(req);
        i_ar       = req;
        i_ar_valid = 1'b1;
        t = 0;
        while (!o_ar_ready && !timeout_hit) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                raise_timeout("AR ready");
            end
        end
        @(negedge clk);
        i_ar_valid = 1'b0;
        beats = 0;
        t = 0;
        while (beats <= int'(len) && !timeout_hit) begin
            i_r_ready = pick_ready(stall);
            if (o_r_valid && i_r_ready) begin
                beats++;
                t = 0;
            end
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                raise_timeout("R beat");
            end
        end
        i_r_ready = 1'b0;
        if (o_r_valid) begin
            report_error("R valid still high after the final beat");
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [63:0] rnd;
        clk         = 1'b0;
        lfsr        = 16'd93;
        errors      = 0;
        checks      = 0;
        err_mark    = 0;
        r_beat      = 0;
        timeout_hit = 1'b0;
        apply_reset();

        write_burst(32'h100, 4'h3, 8'd0, 1'b0, 1'b0);
        read_burst(32'h100, 4'h3, 8'd0, 1'b0);
        end_test(1, "single beat write and read");

        // full preload, then random lanes on top
        write_burst(32'h400, 4'h1, 8'd7, 1'b0, 1'b0);
        write_burst(32'h400, 4'h2, 8'd7, 1'b1, 1'b0);
        read_burst(32'h400, 4'h2, 8'd7, 1'b0);
        end_test(2, "strobe merge");

        // words at both ends are known before the burst that wraps
        write_burst(TOP_ADDR - 32'd24, 4'h4, 8'd2, 1'b0, 1'b0);
        write_burst(32'h0, 4'h4, 8'd4, 1'b0, 1'b0);
        write_burst(TOP_ADDR - 32'd24, 4'h5, 8'd7, 1'b1, 1'b0);
        read_burst(TOP_ADDR - 32'd24, 4'h5, 8'd7, 1'b0);
        read_burst(TOP_ADDR - 32'd24, 4'h6, 8'd2, 1'b0);
        read_burst(32'h0, 4'h6, 8'd4, 1'b0);
        end_test(3, "out of range burst");

        for (int i = 0; i < 4; i++) begin
            rnd = rand_bits(8);
            write_burst(axi_addr_t'(32'h800 + i * 64), rnd[3:0], 8'd3, 1'b0, 1'b1);
            read_burst(axi_addr_t'(32'h800 + i * 64), rnd[7:4], 8'd3, 1'b1);
        end
        end_test(4, "id echo");

        write_burst(32'h1000, 4'h7, 8'd255, 1'b0, 1'b1);
        read_burst(32'h1000, 4'hA, 8'd255, 1'b1);
        end_test(5, "stalled 256 beat burst");

        // AW and AR on the same edge two cycles after B
        apply_reset();
        write_burst(32'h1800, 4'h8, 8'd3, 1'b0, 1'b0);
        @(negedge clk);
        fork
            write_burst(32'h1900, 4'h9, 8'd5, 1'b0, 1'b0);
            read_burst(32'h1800, 4'hB, 8'd3, 1'b0);
        join
        read_burst(32'h1900, 4'hC, 8'd5, 1'b0);
        end_test(6, "concurrent write and read");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== source/axi_ram_top.sv ====
// AXI4 slave RAM with independent write and read sides and no registers added at this level
`timescale 1ns/100ps

module axi_ram_top (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_types_pkg::axi_aw_t i_aw,
    input  logic                   i_aw_valid,
    output logic                   o_aw_ready,
    input  axi_types_pkg::axi_w_t  i_w,
    input  logic                   i_w_valid,
    output logic                   o_w_ready,
    output axi_types_pkg::axi_b_t  o_b,
    output logic                   o_b_valid,
    input  logic                   i_b_ready,
    input  axi_types_pkg::axi_ar_t i_ar,
    input  logic                   i_ar_valid,
    output logic                   o_ar_ready,
    output axi_types_pkg::axi_r_t  o_r,
    output logic                   o_r_valid,
    input  logic                   i_r_ready
);
    import axi_types_pkg::*;
    import mem_types_pkg::*;

    mem_wr_t    mem_wr;
    logic       rd_en;
    mem_index_t rd_index;
    axi_data_t  rd_data;

    axi_write_ctrl u_write_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_aw       (i_aw),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_w        (i_w),
        .i_w_valid  (i_w_valid),
        .o_w_ready  (o_w_ready),
        .o_b        (o_b),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_mem_wr   (mem_wr)
    );

    axi_mem_array u_mem_array (
        .clk        (clk),
        .i_wr       (mem_wr),
        .i_rd_en    (rd_en),
        .i_rd_index (rd_index),
        .o_rd_data  (rd_data)
    );

    axi_read_ctrl u_read_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_ar       (i_ar),
        .i_ar_valid (i_ar_valid),
        .o_ar_ready (o_ar_ready),
        .o_r        (o_r),
        .o_r_valid  (o_r_valid),
        .i_r_ready  (i_r_ready),
        .o_rd_en    (rd_en),
        .o_rd_index (rd_index),
        .i_rd_data  (rd_data)
    );

endmodule

// ==== source/axi_read_ctrl.sv ====
// one read burst at a time with INCR only, each beat costs a fetch cycle and a present cycle
`timescale 1ns/100ps
`include "axi_mem_defs.svh"

module axi_read_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  axi_types_pkg::axi_ar_t     i_ar,
    input  logic                       i_ar_valid,
    output logic                       o_ar_ready,
    output axi_types_pkg::axi_r_t      o_r,
    output logic                       o_r_valid,
    input  logic                       i_r_ready,
    output logic                       o_rd_en,
    output mem_types_pkg::mem_index_t  o_rd_index,
    input  axi_types_pkg::axi_data_t   i_rd_data
);
    import axi_types_pkg::*;
    import mem_types_pkg::*;

    localparam int WORD_W = `AXI_ADDR_W - `AXI_BYTE_OFF_W;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_FETCH,
        R_PRESENT
    } rd_state_t;

    rd_state_t       state;
    rd_state_t       state_nxt;
    mem_index_t      start_index;
    axi_id_t         burst_id;
    axi_len_t        burst_len;
    logic            burst_ok;
    axi_len_t        beat_cnt;
    logic [WORD_W:0] end_word;
    logic            ar_hs;
    logic            r_hs;
    logic            last_beat;

    assign ar_hs     = i_ar_valid && o_ar_ready;
    assign r_hs      = o_r_valid && i_r_ready;
    assign last_beat = (beat_cnt == burst_len);

    // same range rule as the write side
    assign end_word = {1'b0, i_ar.addr[`AXI_ADDR_W-1:`AXI_BYTE_OFF_W]} + (WORD_W+1)'(i_ar.len);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= R_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            R_IDLE: state_nxt = R_ADDR;
            R_ADDR: if (ar_hs) state_nxt = R_FETCH;
            R_FETCH: state_nxt = R_PRESENT;
            R_PRESENT: begin
                if (r_hs) begin
                    state_nxt = last_beat ? R_ADDR : R_FETCH;
                end
            end
            default: state_nxt = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            start_index <= i_ar.addr[`AXI_BYTE_OFF_W +: `MEM_DEPTH_LOG2];
            burst_id    <= i_ar.id;
            burst_len   <= i_ar.len;
            burst_ok    <= (end_word[WORD_W:`MEM_DEPTH_LOG2] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ar_hs) begin
            beat_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // no array access for bursts past the end
    assign o_rd_en    = (state == R_FETCH) && burst_ok;
    assign o_rd_index = start_index + mem_index_t'(beat_cnt);

    assign o_ar_ready = (state == R_ADDR);
    assign o_r_valid  = (state == R_PRESENT);

    // array output register holds the word until the next fetch
    assign o_r.data = burst_ok ? i_rd_data : '0;
    assign o_r.id   = burst_id;
    assign o_r.resp = burst_ok ? RESP_OKAY : RESP_SLVERR;
    assign o_r.last = last_beat;

endmodule

// ==== source/axi_write_ctrl.sv ====
// one write burst at a time with INCR only, beats counted from awlen so wlast is ignored
`timescale 1ns/100ps
`include "axi_mem_defs.svh"

module axi_write_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_types_pkg::axi_aw_t i_aw,
    input  logic                   i_aw_valid,
    output logic                   o_aw_ready,
    input  axi_types_pkg::axi_w_t  i_w,
    input  logic                   i_w_valid,
    output logic                   o_w_ready,
    output axi_types_pkg::axi_b_t  o_b,
    output logic                   o_b_valid,
    input  logic                   i_b_ready,
    output mem_types_pkg::mem_wr_t o_mem_wr
);
    import axi_types_pkg::*;
    import mem_types_pkg::*;

    localparam int WORD_W = `AXI_ADDR_W - `AXI_BYTE_OFF_W;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

    wr_state_t       state;
    wr_state_t       state_nxt;
    mem_index_t      start_index;
    axi_id_t         burst_id;
    axi_len_t        burst_len;
    logic            burst_ok;
    axi_len_t        beat_cnt;
    logic [WORD_W:0] end_word;
    logic            aw_hs;
    logic            w_hs;
    logic            b_hs;
    logic            w_done;

    assign aw_hs  = i_aw_valid && o_aw_ready;
    assign w_hs   = i_w_valid && o_w_ready;
    assign b_hs   = o_b_valid && i_b_ready;
    assign w_done = w_hs && (beat_cnt == burst_len);

    // last word of the burst, spare top bit keeps the carry
    assign end_word = {1'b0, i_aw.addr[`AXI_ADDR_W-1:`AXI_BYTE_OFF_W]} + (WORD_W+1)'(i_aw.len);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            W_IDLE: state_nxt = W_ADDR;
            W_ADDR: if (aw_hs) state_nxt = W_DATA;
            W_DATA: if (w_done) state_nxt = W_RESP;
            W_RESP: if (b_hs) state_nxt = W_ADDR;
            default: state_nxt = W_IDLE;
        endcase
    end

    // request held for the whole burst
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            start_index <= i_aw.addr[`AXI_BYTE_OFF_W +: `MEM_DEPTH_LOG2];
            burst_id    <= i_aw.id;
            burst_len   <= i_aw.len;
            burst_ok    <= (end_word[WORD_W:`MEM_DEPTH_LOG2] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || aw_hs) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign o_aw_ready = (state == W_ADDR);
    assign o_w_ready  = (state == W_DATA);
    assign o_b_valid  = (state == W_RESP);

    assign o_b.id   = burst_id;
    assign o_b.resp = burst_ok ? RESP_OKAY : RESP_SLVERR;

    // out of range bursts take their beats but never write
    assign o_mem_wr.en    = w_hs && burst_ok;
    assign o_mem_wr.index = start_index + mem_index_t'(beat_cnt);
    assign o_mem_wr.data  = i_w.data;
    assign o_mem_wr.strb  = i_w.strb;

endmodule

// ==== source/axi_mem_array.sv ====
// contents come up undefined and a read of a word written in the same cycle returns the old data
`timescale 1ns/100ps
`include "axi_mem_defs.svh"

module axi_mem_array (
    input  logic                      clk,
    input  mem_types_pkg::mem_wr_t    i_wr,
    input  logic                      i_rd_en,
    input  mem_types_pkg::mem_index_t i_rd_index,
    output axi_types_pkg::axi_data_t  o_rd_data
);
    import axi_types_pkg::*;

    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    axi_data_t mem [DEPTH];

    // byte lanes written only where strobed
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (i_wr.strb[b]) begin
                    mem[i_wr.index][b*8 +: 8] <= i_wr.data[b*8 +: 8];
                end
            end
        end
    end

    // output register keeps its word while enable is low
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_index];
        end
    end

endmodule

// ==== source/mem_types_pkg.sv ====
// word index and write port of the on-chip array, sized by MEM_DEPTH_LOG2
`include "axi_mem_defs.svh"

package mem_types_pkg;

    // word index, one word per 64-bit beat
    typedef logic [`MEM_DEPTH_LOG2-1:0] mem_index_t;

    // strobed write, applied at the clock edge where en is high
    typedef struct packed {
        logic                     en;
        mem_index_t               index;
        axi_types_pkg::axi_data_t data;
        axi_types_pkg::axi_strb_t strb;
    } mem_wr_t;

endpackage

// ==== source/axi_types_pkg.sv ====
// field types and channel structs for a 64-bit AXI4 slave without size, burst, lock, cache, prot or qos
`include "axi_mem_defs.svh"

package axi_types_pkg;

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_LEN_W-1:0]  axi_len_t;
    typedef logic [`AXI_RESP_W-1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // write and read requests share one layout
    typedef struct packed {
        axi_addr_t addr;
        axi_id_t   id;
        axi_len_t  len;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_data_t data;
        axi_id_t   id;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

endpackage

// ==== source/axi_mem_defs.svh ====
// the data width stays at 64 bits with 8-byte aligned beats while the memory depth may change freely
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// byte address width
`define AXI_ADDR_W 32

// one beat, full width on every transfer
`define AXI_DATA_W 64

// byte lanes per beat and the address bits below a word
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_BYTE_OFF_W 3

// transaction id and burst length fields
`define AXI_ID_W 4
`define AXI_LEN_W 8
`define AXI_RESP_W 2

// log2 of the number of 64-bit words, 10 gives 8 KiB
`define MEM_DEPTH_LOG2 10

`endif
